// ==== sched_frame_pkg.sv ====
package sched_frame_pkg;

    // program word and message bus
    localparam int unsigned word_w      = 16;
    localparam int unsigned frame_words = 16;  // words per frame, header or instr

    // header word 0 layout
    localparam int unsigned fence_lsb = 6;    // fence code in bits 7:6
    localparam int unsigned fence_w   = 2;
    localparam int unsigned ifcnt_w   = 6;    // instr frame count in bits 5:0

    // fence codes
    localparam logic [fence_w-1:0] fence_none = 2'd0;
    localparam logic [fence_w-1:0] fence_acq  = 2'd1;  // wait for masked cores before instr
    localparam logic [fence_w-1:0] fence_rel  = 2'd2;  // wait for all cores before header

    // header word indexes
    localparam int unsigned hdr_mask_idx   = 1;  // core mask
    localparam int unsigned hdr_r0mask_idx = 2;  // r0 init mask
    localparam int unsigned hdr_r0_first   = 3;  // r0 data runs 3..15

    // tasks per run, same width as the count field in the ctrl register
    localparam int unsigned task_cnt_w = 8;

    // message kinds, one flag each on the core bus
    // order follows the flag ports: core mask, r0 mask, r0, instr
    localparam int unsigned kind_w = 2;

    localparam logic [kind_w-1:0] kind_core_mask = 2'd0;
    localparam logic [kind_w-1:0] kind_r0_mask   = 2'd1;
    localparam logic [kind_w-1:0] kind_r0        = 2'd2;
    localparam logic [kind_w-1:0] kind_instr     = 2'd3;

    // largest instr stream of one task, in words
    localparam int unsigned max_instr_words = ((1 << ifcnt_w) - 1) * frame_words;

endpackage

// ==== sched_bus_pkg.sv ====
package sched_bus_pkg;

    // apb side
    localparam int unsigned paddr_w = 13;
    localparam int unsigned pdata_w = 32;

    // program window, one 16-bit word per 4 bytes
    localparam logic [paddr_w-1:0] mem_base = 13'h0000;
    localparam logic [paddr_w-1:0] mem_top  = 13'h0fff;

    // control register
    localparam logic [paddr_w-1:0] ctrl_addr = 13'h1000;
    localparam int unsigned ctrl_start_bit = 0;   // write 1 to launch a run
    localparam int unsigned ctrl_tcnt_lsb  = 8;   // task count, bits 15:8

    // status register, read only
    localparam logic [paddr_w-1:0] status_addr = 13'h1004;
    localparam int unsigned stat_busy_bit = 0;
    localparam int unsigned stat_done_bit = 1;
    localparam int unsigned stat_fin_lsb  = 8;    // tasks finished, bits 15:8

endpackage

// ==== apb_prog_loader.sv ====
`timescale 1ns/1ps

module apb_prog_loader #(
    parameter int data_depth = 1024
) (
    input  logic                                        clk,
    input  logic                                        reset,
    input  logic                                        psel,
    input  logic                                        penable,
    input  logic                                        pwrite,
    input  logic [sched_bus_pkg::paddr_w-1:0]           paddr,
    input  logic [sched_bus_pkg::pdata_w-1:0]           pwdata,
    input  logic                                        seq_busy,
    input  logic                                        task_done,
    output logic [sched_bus_pkg::pdata_w-1:0]           prdata,
    output logic                                        pready,
    output logic                                        pslverr,
    output logic                                        wr_en,
    output logic [$clog2(data_depth)-1:0]               wr_addr,
    output logic [sched_frame_pkg::word_w-1:0]          wr_data,
    output logic                                        run_start,
    output logic [sched_frame_pkg::task_cnt_w-1:0]      task_count
);

    localparam int addr_w = $clog2(data_depth);
    localparam int tcnt_w = sched_frame_pkg::task_cnt_w;

    logic                                 access;
    logic [sched_bus_pkg::paddr_w-1:0]    mem_off;
    logic [sched_bus_pkg::paddr_w-3:0]    mem_word;
    logic                                 mem_hit, ctrl_hit, stat_hit;
    logic                                 map_err, mem_err, ctrl_err;
    logic                                 ctrl_wr, start_ok;
    logic                                 busy;
    logic                                 seq_busy_q;
    logic                                 done;
    logic [tcnt_w-1:0]                    new_count;
    logic [tcnt_w-1:0]                    fin_cnt;

    assign access  = psel & penable;   // no wait states
    assign pready  = 1'b1;

    // address decode
    assign mem_off  = paddr - sched_bus_pkg::mem_base;
    assign mem_word = mem_off[sched_bus_pkg::paddr_w-1:2];   // byte to word
    assign mem_hit  = (mem_off <= (sched_bus_pkg::mem_top - sched_bus_pkg::mem_base))
                      && (32'(mem_word) < data_depth);
    assign ctrl_hit = (paddr == sched_bus_pkg::ctrl_addr);
    assign stat_hit = (paddr == sched_bus_pkg::status_addr);

    // busy also covers the cycle between the start write and the sequencer taking it
    assign busy      = seq_busy | run_start;
    assign new_count = pwdata[sched_bus_pkg::ctrl_tcnt_lsb +: tcnt_w];

    assign map_err  = !(mem_hit | ctrl_hit | stat_hit);
    assign mem_err  = pwrite & mem_hit & busy;            // program frozen during a run
    assign ctrl_err = pwrite & ctrl_hit & (new_count == '0);
    assign pslverr  = access & (map_err | mem_err | ctrl_err);

    // store write lands on the edge ending the access phase
    assign wr_en   = access & pwrite & mem_hit & !busy;
    assign wr_addr = mem_word[addr_w-1:0];
    assign wr_data = pwdata[sched_frame_pkg::word_w-1:0];

    assign ctrl_wr  = access & pwrite & ctrl_hit & !ctrl_err;
    assign start_ok = ctrl_wr & pwdata[sched_bus_pkg::ctrl_start_bit] & !busy;

    always_ff @(posedge clk) begin
        if (reset) begin
            task_count <= '0;
            run_start  <= 1'b0;
            seq_busy_q <= 1'b0;
            done       <= 1'b0;
            fin_cnt    <= '0;
        end else begin
            seq_busy_q <= seq_busy;
            run_start  <= start_ok;              // one cycle pulse
            if (ctrl_wr)
                task_count <= new_count;
            if (start_ok) begin
                done    <= 1'b0;                 // fresh run
                fin_cnt <= '0;
            end else begin
                if (task_done)
                    fin_cnt <= fin_cnt + 1'b1;
                if (seq_busy_q && !seq_busy)
                    done <= 1'b1;                // falling busy ends the run
            end
        end
    end

    // read mux, program window reads back zero
    always_comb begin
        prdata = '0;
        if (ctrl_hit) begin
            prdata[sched_bus_pkg::ctrl_tcnt_lsb +: tcnt_w] = task_count;
        end else if (stat_hit) begin
            prdata[sched_bus_pkg::stat_busy_bit]          = busy;
            prdata[sched_bus_pkg::stat_done_bit]          = done;
            prdata[sched_bus_pkg::stat_fin_lsb +: tcnt_w] = fin_cnt;
        end
    end

endmodule

// ==== frame_store.sv ====
`timescale 1ns/1ps

module frame_store #(
    parameter int data_depth = 1024
) (
    input  logic                                clk,
    input  logic                                wr_en,
    input  logic [$clog2(data_depth)-1:0]       wr_addr,
    input  logic [sched_frame_pkg::word_w-1:0]  wr_data,
    input  logic                                rd_en,
    input  logic [$clog2(data_depth)-1:0]       rd_addr,
    output logic [sched_frame_pkg::word_w-1:0]  rd_data
);

    // program words, header and instr frames back to back
    logic [sched_frame_pkg::word_w-1:0] mem [data_depth];

    // write port, apb side
    always_ff @(posedge clk) begin
        if (wr_en)
            mem[wr_addr] <= wr_data;
    end

    // read port, sequencer side
    // data valid the cycle after rd_en, holds otherwise
    always_ff @(posedge clk) begin
        if (rd_en)
            rd_data <= mem[rd_addr];
    end

    // loader blocks writes during a run,
    // so a re-read of a stalled word returns the same value

endmodule

// ==== task_sequencer.sv ====
`timescale 1ns/1ps

module task_sequencer #(
    parameter int data_depth = 1024,
    parameter int core_num   = 16
) (
    input  logic                                        clk,
    input  logic                                        reset,
    input  logic                                        run_start,
    input  logic [sched_frame_pkg::task_cnt_w-1:0]      task_count,
    input  logic [sched_frame_pkg::word_w-1:0]          rd_data,
    input  logic                                        core_reading,
    input  logic [core_num-1:0]                         core_ready,
    output logic                                        rd_en,
    output logic [$clog2(data_depth)-1:0]               rd_addr,
    output logic                                        seq_busy,
    output logic                                        task_done,
    output logic [sched_frame_pkg::word_w-1:0]          msg_data,
    output logic                                        core_mask_load,
    output logic                                        r0_mask_load,
    output logic                                        r0_load,
    output logic                                        instr_load
);

    localparam int addr_w = $clog2(data_depth);
    localparam int frm_lg = $clog2(sched_frame_pkg::frame_words);
    localparam int left_w = sched_frame_pkg::ifcnt_w + frm_lg;

    // fsm states
    localparam logic [2:0] s_idle    = 3'd0;
    localparam logic [2:0] s_hdr_rd  = 3'd1;  // read header word 0
    localparam logic [2:0] s_hdr_lat = 3'd2;  // latch fence and frame count
    localparam logic [2:0] s_rel     = 3'd3;  // release fence check
    localparam logic [2:0] s_hsend   = 3'd4;  // header words 1..15
    localparam logic [2:0] s_acq     = 3'd5;  // acquire fence check
    localparam logic [2:0] s_isend   = 3'd6;  // instr frames
    localparam logic [2:0] s_next    = 3'd7;  // task finished

    logic [2:0]                                 state;
    logic [addr_w-1:0]                          ptr;        // head word, in flight or next
    logic [left_w-1:0]                          left;       // words of the phase not yet sent
    logic                                       rd_pend;    // rd_data holds the head word
    logic [sched_frame_pkg::fence_w-1:0]        fence;
    logic [sched_frame_pkg::ifcnt_w-1:0]        ifcnt;
    logic [core_num-1:0]                        task_mask;
    logic [sched_frame_pkg::task_cnt_w-1:0]     tasks_left;

    logic                                       in_stream;
    logic                                       consume;
    logic                                       last_word;
    logic [frm_lg-1:0]                          word_idx;
    logic                                       rel_hold, acq_hold;

    assign seq_busy  = (state != s_idle);
    assign in_stream = (state == s_hsend) || (state == s_isend);
    assign consume   = in_stream && rd_pend && core_reading;   // word goes out this edge
    assign last_word = consume && (left == 1);
    assign word_idx  = ptr[frm_lg-1:0];                      // tasks start frame aligned

    // fences
    assign rel_hold = (fence == sched_frame_pkg::fence_rel) && (core_ready != '1);
    assign acq_hold = (fence == sched_frame_pkg::fence_acq) && ((task_mask & ~core_ready) != '0);

    // read issue: next word after a send, else re-read the stalled head
    always_comb begin
        rd_en   = 1'b0;
        rd_addr = ptr;
        if (state == s_hdr_rd) begin
            rd_en = 1'b1;                        // header word 0
        end else if (in_stream) begin
            if (consume) begin
                rd_en   = (left > 1);
                rd_addr = ptr + 1'b1;
            end else begin
                rd_en = 1'b1;                    // left is nonzero inside a stream
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state          <= s_idle;
            ptr            <= '0;
            left           <= '0;
            rd_pend        <= 1'b0;
            fence          <= '0;
            ifcnt          <= '0;
            task_mask      <= '0;
            tasks_left     <= '0;
            task_done      <= 1'b0;
            msg_data       <= '0;
            core_mask_load <= 1'b0;
            r0_mask_load   <= 1'b0;
            r0_load        <= 1'b0;
            instr_load     <= 1'b0;
        end else begin
            rd_pend        <= in_stream && rd_en;
            task_done      <= 1'b0;
            core_mask_load <= 1'b0;
            r0_mask_load   <= 1'b0;
            r0_load        <= 1'b0;
            instr_load     <= 1'b0;

            if (consume) begin
                msg_data <= rd_data;             // holds on idle cycles
                ptr      <= ptr + 1'b1;
                left     <= left - 1'b1;
                if (state == s_isend)
                    instr_load <= 1'b1;
                else if (word_idx == frm_lg'(sched_frame_pkg::hdr_mask_idx)) begin
                    core_mask_load <= 1'b1;
                    task_mask      <= rd_data[core_num-1:0];  // kept for the acquire check
                end else if (word_idx == frm_lg'(sched_frame_pkg::hdr_r0mask_idx))
                    r0_mask_load <= 1'b1;
                else
                    r0_load <= 1'b1;             // r0 data words
            end

            case (state)
                s_idle: begin
                    if (run_start && task_count != '0) begin
                        tasks_left <= task_count;
                        ptr        <= '0;        // program starts at word 0
                        state      <= s_hdr_rd;
                    end
                end
                s_hdr_rd: state <= s_hdr_lat;
                s_hdr_lat: begin
                    fence <= rd_data[sched_frame_pkg::fence_lsb +: sched_frame_pkg::fence_w];
                    ifcnt <= rd_data[sched_frame_pkg::ifcnt_w-1:0];
                    state <= s_rel;
                end
                s_rel: begin
                    if (!rel_hold) begin
                        ptr   <= ptr + 1'b1;     // skip word 0
                        left  <= left_w'(sched_frame_pkg::frame_words - 1);
                        state <= s_hsend;
                    end
                end
                s_hsend: if (last_word) state <= s_acq;
                s_acq: begin
                    if (!acq_hold) begin
                        if (ifcnt == '0)
                            state <= s_next;     // header only task
                        else begin
                            left  <= {ifcnt, {frm_lg{1'b0}}};
                            state <= s_isend;
                        end
                    end
                end
                s_isend: if (last_word) state <= s_next;
                s_next: begin
                    // ptr already sits on the next header
                    task_done  <= 1'b1;
                    tasks_left <= tasks_left - 1'b1;
                    state      <= (tasks_left == 1) ? s_idle : s_hdr_rd;
                end
                default: state <= s_idle;
            endcase
        end
    end

endmodule

// ==== gpu_sched_top.sv ====
`timescale 1ns/1ps

module gpu_sched_top #(
    parameter int data_depth = 1024,
    parameter int core_num   = 16
) (
    input  logic                                clk,
    input  logic                                reset,
    // apb slave
    input  logic                                psel,
    input  logic                                penable,
    input  logic                                pwrite,
    input  logic [sched_bus_pkg::paddr_w-1:0]   paddr,
    input  logic [sched_bus_pkg::pdata_w-1:0]   pwdata,
    output logic [sched_bus_pkg::pdata_w-1:0]   prdata,
    output logic                                pready,
    output logic                                pslverr,
    // core side
    input  logic                                core_reading,
    input  logic [core_num-1:0]                 core_ready,
    output logic [sched_frame_pkg::word_w-1:0]  msg_data,
    output logic                                core_mask_load,
    output logic                                r0_mask_load,
    output logic                                r0_load,
    output logic                                instr_load
);

    localparam int addr_w = $clog2(data_depth);

    logic                                       wr_en, rd_en;
    logic [addr_w-1:0]                          wr_addr, rd_addr;
    logic [sched_frame_pkg::word_w-1:0]         wr_data, rd_data;
    logic                                       run_start, seq_busy, task_done;
    logic [sched_frame_pkg::task_cnt_w-1:0]     task_count;

    apb_prog_loader #(.data_depth(data_depth)) u_loader (
        .clk, .reset, .psel, .penable, .pwrite, .paddr, .pwdata,
        .seq_busy, .task_done, .prdata, .pready, .pslverr,
        .wr_en, .wr_addr, .wr_data, .run_start, .task_count
    );

    frame_store #(.data_depth(data_depth)) u_store (
        .clk, .wr_en, .wr_addr, .wr_data, .rd_en, .rd_addr, .rd_data
    );

    task_sequencer #(.data_depth(data_depth), .core_num(core_num)) u_seq (
        .clk, .reset, .run_start, .task_count, .rd_data, .core_reading, .core_ready,
        .rd_en, .rd_addr, .seq_busy, .task_done, .msg_data,
        .core_mask_load, .r0_mask_load, .r0_load, .instr_load
    );

endmodule

// ==== tb_gpu_sched_asserts.sv ====
`timescale 1ns/1ps

module tb_gpu_sched_asserts #(
    parameter bit seq_side = 1'b1      // sequencer outputs, else apb response
) (
    input logic       clk,
    input logic       reset,
    input logic [3:0] flags,           // core mask, r0 mask, r0, instr
    input logic       core_reading,
    input logic       seq_busy,
    input logic       pready
);

    if (seq_side) begin : g_seq
        // one kind per message at most
        flags_onehot: assert property (@(posedge clk) disable iff (reset) $onehot0(flags))
            else $error("more than one message flag high: %b", flags);

        // paused cycle is never followed by a transfer
        no_flag_after_pause: assert property (
            @(posedge clk) disable iff (reset) !core_reading |=> flags == '0)
            else $error("message flag raised after core_reading was low");

        idle_after_reset: assert property (@(posedge clk) reset |=> !seq_busy)
            else $error("seq_busy high right after reset");
    end else begin : g_apb
        pready_high: assert property (@(posedge clk) pready)
            else $error("pready dropped low");
    end

endmodule

bind task_sequencer tb_gpu_sched_asserts #(.seq_side(1'b1)) seq_checks (
    .clk, .reset, .flags({core_mask_load, r0_mask_load, r0_load, instr_load}),
    .core_reading, .seq_busy, .pready(1'b1)
);

bind apb_prog_loader tb_gpu_sched_asserts #(.seq_side(1'b0)) loader_checks (
    .clk, .reset, .flags(4'b0000), .core_reading(1'b1), .seq_busy, .pready
);

// ==== tb_gpu_sched.sv ====
`timescale 1ns/1ps

module tb_gpu_sched;

    localparam int core_num = 16;
    localparam int n_tasks  = 3;    // every program here has three tasks

    logic                                clk = 1'b0;
    logic                                reset;
    logic                                psel, penable, pwrite;
    logic [sched_bus_pkg::paddr_w-1:0]   paddr;
    logic [31:0]                         pwdata, prdata;
    logic                                pready, pslverr;
    logic                                core_reading = 1'b1;
    logic [core_num-1:0]                 core_ready;
    logic [15:0]                         msg_data;
    logic                                core_mask_load, r0_mask_load, r0_load, instr_load;

    logic [15:0] prog [0:1023];         // program image, same as the store after loading
    int          prog_len;
    logic [15:0] exp_word [$];          // expected stream, front is the next message
    logic [1:0]  exp_kind [$];
    int          exp_task [$];
    int          errors = 0;
    int          checked = 0;
    int          rel_task = -1;         // task whose messages need all cores ready
    int          acq_task = -1;         // task whose instr words need the masked cores
    logic [15:0] acq_mask = '0;
    logic        rand_reading = 1'b0;
    logic        wd_armed = 1'b0;
    int          wd_count, wd_limit, held;
    logic [31:0] rdata;
    logic        err;

    gpu_sched_top #(.data_depth(1024), .core_num(core_num)) UUT (.*);

    always #5 clk = ~clk;

    // back-pressure from the cores
    always @(posedge clk)
        core_reading <= rand_reading ? 1'($urandom % 2) : 1'b1;

    task automatic check_val(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    // one apb transfer, setup then access; response lands in err and rdata
    task automatic apb_xfer(input logic wr, input logic [12:0] addr, input logic [31:0] wdata);
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= wr;
        paddr   <= addr;
        pwdata  <= wdata;
        @(posedge clk);
        penable <= 1'b1;
        @(negedge clk);                 // mid access phase
        err   = pslverr;
        rdata = prdata;
        check_val("pready", 32'(pready), 1);   // no wait states
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    // random three-task program, one task may carry a fence; then load it
    task automatic make_program(input int fence_task, input logic [1:0] fence,
                                input logic [15:0] fence_mask);
        int nfrm;
        logic [1:0] fcode;
        prog_len = 0;
        for (int t = 0; t < n_tasks; t++) begin
            nfrm  = 1 + int'($urandom % 3);     // 1..3 instr frames
            fcode = (t == fence_task) ? fence : sched_frame_pkg::fence_none;
            prog[prog_len] = {8'($urandom), fcode, 6'(nfrm)};
            for (int i = 1; i < 16 * (nfrm + 1); i++)
                prog[prog_len + i] = 16'($urandom);
            if (t == fence_task)
                prog[prog_len + 1] = fence_mask;
            prog_len += 16 * (nfrm + 1);
        end
        for (int w = 0; w < prog_len; w++) begin
            apb_xfer(1'b1, sched_bus_pkg::mem_base + 13'(4 * w), {16'h0, prog[w]});
            check_val("pslverr", 32'(err), 0);
        end
    endtask

    // reference: header words 1..15 then every instr word, task after task
    function automatic void build_expected();
        int base;
        int n_instr;
        base = 0;
        exp_word.delete();
        exp_kind.delete();
        exp_task.delete();
        for (int t = 0; t < n_tasks; t++) begin
            n_instr = 16 * int'(prog[base][sched_frame_pkg::ifcnt_w-1:0]);
            for (int i = 1; i < 16; i++) begin
                exp_word.push_back(prog[base + i]);
                exp_task.push_back(t);
                if (i == sched_frame_pkg::hdr_mask_idx)
                    exp_kind.push_back(sched_frame_pkg::kind_core_mask);
                else if (i == sched_frame_pkg::hdr_r0mask_idx)
                    exp_kind.push_back(sched_frame_pkg::kind_r0_mask);
                else
                    exp_kind.push_back(sched_frame_pkg::kind_r0);
            end
            for (int j = 0; j < n_instr; j++) begin
                exp_word.push_back(prog[base + 16 + j]);
                exp_kind.push_back(sched_frame_pkg::kind_instr);
                exp_task.push_back(t);
            end
            base += 16 + n_instr;
        end
    endfunction

    task automatic start_run();
        build_expected();
        wd_limit = 20 * exp_word.size() + 500;
        wd_count = 0;
        wd_armed = 1'b1;
        apb_xfer(1'b1, sched_bus_pkg::ctrl_addr, 32'((n_tasks << 8) | 1));
        check_val("pslverr", 32'(err), 0);
    endtask

    task automatic finish_run();
        rdata = '0;
        while (!rdata[sched_bus_pkg::stat_done_bit])
            apb_xfer(1'b0, sched_bus_pkg::status_addr, '0);
        check_val("messages_left", 32'(exp_word.size()), 0);
        check_val("status", rdata, 32'((n_tasks << 8) | 2));  // done, idle, all finished
        wd_armed = 1'b0;
    endtask

    // one expected entry per flagged cycle
    always @(negedge clk) begin : compare
        logic [1:0] kind;
        if (!reset && (core_mask_load | r0_mask_load | r0_load | instr_load)) begin
            kind = instr_load   ? sched_frame_pkg::kind_instr :
                   r0_load      ? sched_frame_pkg::kind_r0 :
                   r0_mask_load ? sched_frame_pkg::kind_r0_mask : sched_frame_pkg::kind_core_mask;
            if (exp_word.size() == 0) begin
                $display("unexpected message %h at %0t after the expected stream", msg_data, $time);
                errors++;
            end else begin
                check_val("msg_kind", 32'(kind), 32'(exp_kind[0]));
                check_val("msg_data", 32'(msg_data), 32'(exp_word[0]));
                if (exp_task[0] == rel_task && core_ready != '1) begin
                    $display("task %0d sent a message at %0t while cores were busy", rel_task, $time);
                    errors++;
                end
                if (exp_task[0] == acq_task && exp_kind[0] == sched_frame_pkg::kind_instr
                    && (core_ready & acq_mask) != acq_mask) begin
                    $display("task %0d sent an instr at %0t before its cores were ready",
                             acq_task, $time);
                    errors++;
                end
                void'(exp_word.pop_front());
                void'(exp_kind.pop_front());
                void'(exp_task.pop_front());
                checked++;
            end
        end
    end

    always @(posedge clk) begin
        if (wd_armed) begin
            wd_count++;
            if (wd_count > wd_limit) begin
                $display("timeout: run stuck with %0d messages still expected", exp_word.size());
                $display(">>> FAIL");
                $finish;
            end
        end
    end

    initial begin
        void'($urandom(1));
        reset      <= 1'b1;
        psel       <= 1'b0;
        penable    <= 1'b0;
        pwrite     <= 1'b0;
        paddr      <= '0;
        pwdata     <= '0;
        core_ready <= '1;
        repeat (10) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        check_val("flags", 32'({core_mask_load, r0_mask_load, r0_load, instr_load}), 0);
        check_val("msg_data", 32'(msg_data), 0);
        apb_xfer(1'b0, sched_bus_pkg::status_addr, '0);
        check_val("status", rdata, 0);
        apb_xfer(1'b1, sched_bus_pkg::ctrl_addr, 32'h1);   // start, zero tasks
        check_val("pslverr", 32'(err), 1);
        apb_xfer(1'b0, sched_bus_pkg::status_addr, '0);
        check_val("status", rdata, 0);

        make_program(-1, sched_frame_pkg::fence_none, '0);
        start_run();
        finish_run();
        rand_reading <= 1'b1;           // same program, stalls
        start_run();
        finish_run();

        // release fence on task 1, cores 8..11 busy
        make_program(1, sched_frame_pkg::fence_rel, 16'hffff);
        core_ready <= 16'hf0ff;
        rel_task = 1;
        start_run();
        while (exp_task.size() > 0 && exp_task[0] == 0)
            @(posedge clk);
        held = exp_word.size();
        repeat (20) @(posedge clk);
        check_val("rel_held_len", 32'(exp_word.size()), 32'(held));
        core_ready <= '1;
        finish_run();
        rel_task = -1;

        // acquire fence on task 1, core 5 in mask busy, core 12 outside it
        acq_mask = 16'h00f0;
        make_program(1, sched_frame_pkg::fence_acq, acq_mask);
        core_ready <= 16'hefdf;
        acq_task = 1;
        start_run();
        while (exp_task.size() > 0
               && !(exp_task[0] == 1 && exp_kind[0] == sched_frame_pkg::kind_instr))
            @(posedge clk);
        held = exp_word.size();
        repeat (20) @(posedge clk);
        check_val("acq_held_len", 32'(exp_word.size()), 32'(held));
        core_ready <= 16'hefff;         // core 12 stays busy
        finish_run();
        acq_task = -1;
        core_ready <= '1;

        // program write while running is refused
        start_run();
        apb_xfer(1'b1, sched_bus_pkg::mem_base + 13'd20, 32'h0000_dead);
        check_val("pslverr", 32'(err), 1);
        finish_run();
        start_run();
        finish_run();

        $display("run complete: %0d messages compared, %0d errors", checked, errors);
        if (errors == 0)
            $display(">>> PASS");
        else
            $display(">>> FAIL");
        $finish;
    end

endmodule

// ==== build.f ====
sched_frame_pkg.sv
sched_bus_pkg.sv
apb_prog_loader.sv
frame_store.sv
task_sequencer.sv
gpu_sched_top.sv
tb_gpu_sched_asserts.sv
tb_gpu_sched.sv

// ==== Makefile ====
TOP := tb_gpu_sched
OBJ := obj_dir

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
		-Mdir $(OBJ) -f build.f

run: compile
	@out="$$(./$(OBJ)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q '^>>> PASS$$'

clean:
	rm -rf $(OBJ)
